//--- include/rvCore_config.svh
`ifndef RVCORE_CONFIG_SVH
`define RVCORE_CONFIG_SVH

//////////////////////////////////////////////////
// core widths
//////////////////////////////////////////////////

// data path and byte address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// word address into instruction memory, 8 KiB of code
`define RV_IMEM_AW 11

//////////////////////////////////////////////////
// reset state
//////////////////////////////////////////////////

// first fetch address
`define RV_PC_RESET 32'h0000_0000

`endif

//--- hdl/rvCore_pkg.sv
`include "rvCore_config.svh"

package rvCore_pkg;

    typedef logic [`RV_XLEN-1:0]    word_t;     // one data word
    typedef logic [4:0]             regAddr_t;  // x0..x31
    typedef logic [`RV_IMEM_AW-1:0] imemAddr_t; // instruction word address

    // alu control encodings
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluOp_e;

    typedef enum logic [1:0] {
        immI = 2'b00,
        immS = 2'b01,
        immB = 2'b10,
        immJ = 2'b11
    } immSel_e;

    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01, // also marks a load for the hazard unit
        resPcPlus4 = 2'b10  // jal link value
    } resultSel_e;

    typedef enum logic [1:0] {
        fwdReg = 2'b00, // value read in decode
        fwdWb  = 2'b01,
        fwdMem = 2'b10
    } fwdSel_e;

    //////////////////////////////////////////////////
    // stage bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        logic       regWrite;
        resultSel_e resultSel;
        logic       memWrite;
        logic       jump;
        logic       branch;
        aluOp_e     aluOp;
        logic       aluSrcImm; // srcB from immediate
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t pcPlus4;
    } ifId_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    rd1;
        word_t    rd2;
        word_t    pc;
        word_t    pcPlus4;
        word_t    immExt;
        regAddr_t rs1;
        regAddr_t rs2;
        regAddr_t rd;
    } idEx_t;

    typedef struct packed {
        logic       regWrite;
        resultSel_e resultSel;
        logic       memWrite;
        word_t      aluResult;
        word_t      writeData; // store data after forwarding
        word_t      pcPlus4;
        regAddr_t   rd;
    } exMem_t;

    typedef struct packed {
        logic       regWrite;
        resultSel_e resultSel;
        word_t      aluResult;
        word_t      readData;
        word_t      pcPlus4;
        regAddr_t   rd;
    } memWb_t;

endpackage

//--- hdl/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder import rvCore_pkg::*; (
    input  word_t   instr,
    output ctrl_t   ctrl,
    output immSel_e immSel
);

    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opReg   = 7'b0110011;
    localparam logic [6:0] opBeq   = 7'b1100011;
    localparam logic [6:0] opImm   = 7'b0010011;
    localparam logic [6:0] opJal   = 7'b1101111;

    ctrl_t      mainCtrl;
    logic [1:0] aluClass;  // 00 add, 01 sub, 1x by funct3
    logic       rtypeSub;
    aluOp_e     aluOp;

    //////////////////////////////////////////////////
    // main decoder
    //////////////////////////////////////////////////
    always_comb begin
        mainCtrl = '0;     // unknown opcode does nothing
        immSel   = immI;
        aluClass = 2'b00;
        case (instr[6:0])
            opLoad: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.resultSel = resMem;
                mainCtrl.aluSrcImm = 1'b1; // base + offset
            end
            opStore: begin
                mainCtrl.memWrite  = 1'b1;
                mainCtrl.aluSrcImm = 1'b1;
                immSel             = immS;
            end
            opReg: begin
                mainCtrl.regWrite = 1'b1;
                aluClass          = 2'b10;
            end
            opBeq: begin
                mainCtrl.branch = 1'b1;
                immSel          = immB;
                aluClass        = 2'b01; // compare by subtraction
            end
            opImm: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.aluSrcImm = 1'b1;
                aluClass           = 2'b10;
            end
            opJal: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.resultSel = resPcPlus4;
                mainCtrl.jump      = 1'b1;
                immSel             = immJ;
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // alu decoder
    //////////////////////////////////////////////////
    assign rtypeSub = instr[30] & instr[5]; // funct7 bit 5, R-type only

    always_comb begin
        case (aluClass)
            2'b00:   aluOp = aluAdd;
            2'b01:   aluOp = aluSub;
            default: begin
                case (instr[14:12])
                    3'b000:  aluOp = rtypeSub ? aluSub : aluAdd;
                    3'b010:  aluOp = aluSlt;
                    3'b110:  aluOp = aluOr;
                    3'b111:  aluOp = aluAnd;
                    default: aluOp = aluAdd;
                endcase
            end
        endcase
    end

    always_comb begin
        ctrl       = mainCtrl;
        ctrl.aluOp = aluOp;
    end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps
`include "rvCore_config.svh"

module regFile import rvCore_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  regAddr_t rs1,
    input  regAddr_t rs2,
    input  regAddr_t rd,
    input  logic     writeEn,
    input  word_t    writeData,
    output word_t    rd1,
    output word_t    rd2
);

    word_t regs [`RV_NREGS];

    // falling edge write, so decode reads the new value in the same cycle
    always_ff @(negedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (rd != '0)) begin
            regs[rd] <= writeData;    // x0 never written
        end
    end

    // x0 reads as zero
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hdl/fetchStage.sv
`timescale 1ns/1ps
`include "rvCore_config.svh"

module fetchStage import rvCore_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      stallF,
    input  logic      stallD,
    input  logic      flushD,
    input  logic      redirect,
    input  word_t     pcTarget,
    input  word_t     imemData,
    output imemAddr_t imemAddr,
    output logic      imemRe,
    output ifId_t     ifId
);

    word_t pc;
    word_t pcPlus4;
    word_t pcNext;

    assign pcPlus4 = pc + word_t'(4);
    assign pcNext  = redirect ? pcTarget : pcPlus4; // redirect from execute wins

    // pc frozen during a load-use bubble
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pc <= `RV_PC_RESET;
        end else if (!stallF) begin
            pc <= pcNext;
        end
    end

    assign imemAddr = pc[`RV_IMEM_AW+1:2]; // byte pc to word address
    assign imemRe   = ~stallF;

    //////////////////////////////////////////////////
    // fetch/decode register
    //////////////////////////////////////////////////
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ifId <= '0;
        end else if (flushD) begin
            ifId <= '0;                // wrong-path fetch becomes a nop
        end else if (!stallD) begin
            ifId <= '{instr: imemData, pc: pc, pcPlus4: pcPlus4};
        end
    end

endmodule

//--- hdl/decodeStage.sv
`timescale 1ns/1ps
`include "rvCore_config.svh"

module decodeStage import rvCore_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  ifId_t    ifId,
    input  logic     flushE,
    input  logic     wbRegWrite,
    input  regAddr_t wbRd,
    input  word_t    wbResult,
    output regAddr_t rs1D,
    output regAddr_t rs2D,
    output idEx_t    idEx
);

    word_t    instr;
    ctrl_t    ctrlD;
    immSel_e  immSel;
    regAddr_t rdD;
    word_t    rd1D, rd2D;
    word_t    immExtD;

    assign instr = ifId.instr;
    assign rs1D  = instr[19:15];
    assign rs2D  = instr[24:20];
    assign rdD   = instr[11:7];

    controlDecoder decoder (
        .instr(instr), .ctrl(ctrlD), .immSel(immSel)
    );

    regFile regs (
        .clk(clk), .rst(rst),
        .rs1(rs1D), .rs2(rs2D), .rd(wbRd),
        .writeEn(wbRegWrite), .writeData(wbResult),
        .rd1(rd1D), .rd2(rd2D)
    );

    //////////////////////////////////////////////////
    // immediate extension
    //////////////////////////////////////////////////
    always_comb begin
        case (immSel)
            immI: immExtD = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
            immS: immExtD = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            immB: immExtD = {{(`RV_XLEN-12){instr[31]}}, instr[7], instr[30:25],
                             instr[11:8], 1'b0};
            immJ: immExtD = {{(`RV_XLEN-20){instr[31]}}, instr[19:12], instr[20],
                             instr[30:21], 1'b0};
            default: immExtD = '0;
        endcase
    end

    // decode/execute register, flushed on bubble or redirect
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            idEx <= '0;
        end else if (flushE) begin
            idEx <= '0;
        end else begin
            idEx <= '{ctrl: ctrlD, rd1: rd1D, rd2: rd2D,
                      pc: ifId.pc, pcPlus4: ifId.pcPlus4, immExt: immExtD,
                      rs1: rs1D, rs2: rs2D, rd: rdD};
        end
    end

endmodule

//--- hdl/executeStage.sv
`timescale 1ns/1ps

module executeStage import rvCore_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  idEx_t   idEx,
    input  fwdSel_e fwdA,
    input  fwdSel_e fwdB,
    input  word_t   wbResult,
    output logic    redirect,
    output word_t   pcTarget,
    output exMem_t  exMem
);

    word_t  srcA, srcB;
    word_t  writeDataE;      // rs2 after bypass, store data
    word_t  aluResult;
    logic   zero;
    exMem_t exMemNext;

    // operand bypass mux
    function automatic word_t fwdMux(input fwdSel_e sel, input word_t regVal,
                                     input word_t wbVal, input word_t memVal);
        case (sel)
            fwdWb:   return wbVal;
            fwdMem:  return memVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA       = fwdMux(fwdA, idEx.rd1, wbResult, exMem.aluResult);
    assign writeDataE = fwdMux(fwdB, idEx.rd2, wbResult, exMem.aluResult);
    assign srcB       = idEx.ctrl.aluSrcImm ? idEx.immExt : writeDataE;

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////
    always_comb begin
        case (idEx.ctrl.aluOp)
            aluAdd:  aluResult = srcA + srcB;
            aluSub:  aluResult = srcA - srcB;
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            aluSlt:  aluResult = ($signed(srcA) < $signed(srcB)) ? word_t'(1) : '0;
            default: aluResult = '0;
        endcase
    end

    assign zero     = (aluResult == '0);     // beq equal
    assign pcTarget = idEx.pc + idEx.immExt; // beq and jal share this adder
    assign redirect = idEx.ctrl.jump | (idEx.ctrl.branch & zero);

    always_comb begin
        exMemNext           = '0;
        exMemNext.regWrite  = idEx.ctrl.regWrite;
        exMemNext.resultSel = idEx.ctrl.resultSel;
        exMemNext.memWrite  = idEx.ctrl.memWrite;
        exMemNext.aluResult = aluResult;
        exMemNext.writeData = writeDataE;
        exMemNext.pcPlus4   = idEx.pcPlus4;
        exMemNext.rd        = idEx.rd;
    end

    // execute/memory register
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            exMem <= '0;
        end else begin
            exMem <= exMemNext;
        end
    end

endmodule

//--- hdl/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import rvCore_pkg::*; (
    input  regAddr_t rs1D,
    input  regAddr_t rs2D,
    input  idEx_t    idEx,
    input  exMem_t   exMem,
    input  logic     wbRegWrite,
    input  regAddr_t wbRd,
    input  logic     redirect,
    output fwdSel_e  fwdA,
    output fwdSel_e  fwdB,
    output logic     stallF,
    output logic     stallD,
    output logic     flushD,
    output logic     flushE
);

    logic loadE;
    logic lwStall;

    // youngest producer first, x0 never bypassed
    function automatic fwdSel_e pickFwd(input regAddr_t src, input exMem_t m,
                                        input logic wbWe, input regAddr_t wbDst);
        if (src == '0) begin
            return fwdReg;
        end else if (m.regWrite && (m.rd == src)) begin
            return fwdMem;
        end else if (wbWe && (wbDst == src)) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign fwdA = pickFwd(idEx.rs1, exMem, wbRegWrite, wbRd);
    assign fwdB = pickFwd(idEx.rs2, exMem, wbRegWrite, wbRd);

    // load in execute whose result decode needs next cycle
    assign loadE   = (idEx.ctrl.resultSel == resMem);
    assign lwStall = loadE && (idEx.rd != '0) && ((idEx.rd == rs1D) || (idEx.rd == rs2D));

    assign stallF = lwStall;
    assign stallD = lwStall;
    assign flushD = redirect;             // kill fetched wrong-path word
    assign flushE = lwStall | redirect;   // bubble or wrong-path decode

endmodule

//--- hdl/memWbStage.sv
`timescale 1ns/1ps

module memWbStage import rvCore_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  exMem_t   exMem,
    input  word_t    dmemReadData,
    output word_t    dmemAddr,
    output word_t    dmemWriteData,
    output logic     dmemWrite,
    output logic     wbRegWrite,
    output regAddr_t wbRd,
    output word_t    wbResult
);

    memWb_t memWb;

    // data bus straight from the memory-stage bundle
    assign dmemAddr      = exMem.aluResult;
    assign dmemWriteData = exMem.writeData;
    assign dmemWrite     = exMem.memWrite;

    // memory/writeback register, read data captured here
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            memWb <= '0;
        end else begin
            memWb <= '{regWrite: exMem.regWrite, resultSel: exMem.resultSel,
                       aluResult: exMem.aluResult, readData: dmemReadData,
                       pcPlus4: exMem.pcPlus4, rd: exMem.rd};
        end
    end

    //////////////////////////////////////////////////
    // result select
    //////////////////////////////////////////////////
    always_comb begin
        case (memWb.resultSel)
            resMem:     wbResult = memWb.readData;
            resPcPlus4: wbResult = memWb.pcPlus4;  // jal link
            default:    wbResult = memWb.aluResult;
        endcase
    end

    assign wbRegWrite = memWb.regWrite;
    assign wbRd       = memWb.rd;

endmodule

//--- hdl/rvCore.sv
`timescale 1ns/1ps

module rvCore import rvCore_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // instruction bus
    output imemAddr_t imemAddr,
    output logic      imemRe,
    input  word_t     imemData,
    // data bus
    output word_t     dmemAddr,
    output logic      dmemWrite,
    output word_t     dmemWriteData,
    input  word_t     dmemReadData
);

    ifId_t    ifId;
    idEx_t    idEx;
    exMem_t   exMem;

    regAddr_t rs1D, rs2D;     // decode sources for the stall check
    fwdSel_e  fwdA, fwdB;
    logic     stallF, stallD;
    logic     flushD, flushE;
    logic     redirect;       // taken beq or jal in execute
    word_t    pcTarget;

    // writeback result, shared by regfile and bypass
    logic     wbRegWrite;
    regAddr_t wbRd;
    word_t    wbResult;

    fetchStage fetch (
        .clk(clk), .rst(rst),
        .stallF(stallF), .stallD(stallD), .flushD(flushD),
        .redirect(redirect), .pcTarget(pcTarget),
        .imemData(imemData), .imemAddr(imemAddr), .imemRe(imemRe),
        .ifId(ifId)
    );

    decodeStage decode (
        .clk(clk), .rst(rst), .ifId(ifId), .flushE(flushE),
        .wbRegWrite(wbRegWrite), .wbRd(wbRd), .wbResult(wbResult),
        .rs1D(rs1D), .rs2D(rs2D), .idEx(idEx)
    );

    executeStage execute (
        .clk(clk), .rst(rst), .idEx(idEx),
        .fwdA(fwdA), .fwdB(fwdB), .wbResult(wbResult),
        .redirect(redirect), .pcTarget(pcTarget), .exMem(exMem)
    );

    memWbStage memWb (
        .clk(clk), .rst(rst), .exMem(exMem), .dmemReadData(dmemReadData),
        .dmemAddr(dmemAddr), .dmemWriteData(dmemWriteData), .dmemWrite(dmemWrite),
        .wbRegWrite(wbRegWrite), .wbRd(wbRd), .wbResult(wbResult)
    );

    hazardUnit hazard (
        .rs1D(rs1D), .rs2D(rs2D), .idEx(idEx), .exMem(exMem),
        .wbRegWrite(wbRegWrite), .wbRd(wbRd), .redirect(redirect),
        .fwdA(fwdA), .fwdB(fwdB),
        .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
    );

endmodule

//--- sim/rvCore_assert.sv
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvCore_assert import rvCore_pkg::*; (
    input logic      clk,
    input logic      rst,
    input imemAddr_t imemAddr,
    input logic      imemRe,
    input word_t     dmemAddr,
    input logic      dmemWrite,
    input word_t     dmemWriteData
);

    localparam int    numStores    = 10;
    localparam word_t sentinelAddr = 32'h0000_003c; // only the skipped sw x1 targets it

    // word address of the sw at 0x40 behind the load-use add
    localparam imemAddr_t loadUseFetch = 11'h010;

    // stores in program order as worked out by hand from the ISA
    localparam word_t expAddr [numStores] = '{
        32'h00, 32'h04, 32'h08, 32'h0c, 32'h10,
        32'h14, 32'h18, 32'h1c, 32'h20, 32'h24
    };
    localparam word_t expData [numStores] = '{
        32'h0000_0011,  // add 5 + 12
        32'hffff_fff4,  // sub 5 - 17
        32'h0000_0004,  // and -12 & 12
        32'h0000_0015,  // or 4 | 17
        32'h0000_0001,  // slt -12 < 5
        32'hffff_fffe,  // addi 1 - 3
        32'hd000_0085,  // lw 0xd0000080 then add 5
        32'h0000_000c,  // beq fall-through stores x2
        32'h0000_0058,  // jal link 0x54 + 4
        32'h0000_0000   // x0 after addi x0
    };

    int    storeIdx;
    logic  inTable;
    word_t expAddrNow, expDataNow;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            storeIdx <= 0;
        end else if (dmemWrite) begin
            storeIdx <= storeIdx + 1; // one per sw reaching memory
        end
    end

    assign inTable    = (storeIdx < numStores);
    assign expAddrNow = inTable ? expAddr[storeIdx] : '0;
    assign expDataNow = inTable ? expData[storeIdx] : '0;

    //////////////////////////////////////////////////
    // reset behavior
    //////////////////////////////////////////////////
    resetNoStore: assert property (@(posedge clk) rst |-> !dmemWrite)
        else begin
            $error("CHECK FAILED t=%0t dmemWrite expected 0 got %b", $time, $sampled(dmemWrite));
            rvCore_tb.errCount++;
        end

    firstFetch: assert property (@(posedge clk) $fell(rst) |-> (imemAddr == '0) && imemRe)
        else begin
            $error("CHECK FAILED t=%0t imemAddr expected 0 got %h (imemRe %b)",
                   $time, $sampled(imemAddr), $sampled(imemRe));
            rvCore_tb.errCount++;
        end

    //////////////////////////////////////////////////
    // load-use bubble
    //////////////////////////////////////////////////

    // first cycle on 0x40 is the stall cycle, fetch not enabled
    loadUseStall: assert property (@(posedge clk) disable iff (rst)
                                   $changed(imemAddr) && (imemAddr == loadUseFetch) |-> !imemRe)
        else begin
            $error("CHECK FAILED t=%0t imemRe expected 0 got %b",
                   $time, $sampled(imemRe));
            rvCore_tb.errCount++;
        end

    //////////////////////////////////////////////////
    // store stream
    //////////////////////////////////////////////////
    storeAddr: assert property (@(posedge clk) disable iff (rst)
                                dmemWrite && inTable |-> dmemAddr == expAddrNow)
        else begin
            $error("CHECK FAILED t=%0t dmemAddr expected %h got %h",
                   $time, $sampled(expAddrNow), $sampled(dmemAddr));
            rvCore_tb.errCount++;
        end

    storeData: assert property (@(posedge clk) disable iff (rst)
                                dmemWrite && inTable |-> dmemWriteData == expDataNow)
        else begin
            $error("CHECK FAILED t=%0t dmemWriteData expected %h got %h",
                   $time, $sampled(expDataNow), $sampled(dmemWriteData));
            rvCore_tb.errCount++;
        end

    noExtraStore: assert property (@(posedge clk) disable iff (rst) dmemWrite |-> inTable)
        else begin
            $error("store beyond the last expected one at t=%0t, address %h",
                   $time, $sampled(dmemAddr));
            rvCore_tb.errCount++;
        end

    // wrong-path sw after a taken beq or jal must never land
    noSentinel: assert property (@(posedge clk) disable iff (rst)
                                 dmemWrite |-> dmemAddr != sentinelAddr)
        else begin
            $error("skipped sw wrote the sentinel address at t=%0t", $time);
            rvCore_tb.errCount++;
        end

endmodule

//--- sim/rvCore_tb.sv
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvCore_tb import rvCore_pkg::*; ();

    localparam int    progLen        = 26;
    localparam int    numStores      = 10;
    localparam int    watchdogCycles = progLen * 3 + 50;
    localparam word_t nopInstr       = 32'h0000_0013; // addi x0, x0, 0

    //////////////////////////////////////////////////
    // program image, one word per instruction
    //////////////////////////////////////////////////
    localparam word_t progImage [progLen] = '{
        32'h0050_0093,  // 00 addi x1, x0, 5
        32'h00c0_0113,  // 04 addi x2, x0, 12
        32'h0020_81b3,  // 08 add  x3, x1, x2
        32'h0030_2023,  // 0c sw   x3, 0(x0)
        32'h4030_8233,  // 10 sub  x4, x1, x3
        32'h0040_2223,  // 14 sw   x4, 4(x0)
        32'h0022_72b3,  // 18 and  x5, x4, x2
        32'h0050_2423,  // 1c sw   x5, 8(x0)
        32'h0032_e333,  // 20 or   x6, x5, x3
        32'h0060_2623,  // 24 sw   x6, 12(x0)
        32'h0012_23b3,  // 28 slt  x7, x4, x1
        32'h0070_2823,  // 2c sw   x7, 16(x0)
        32'hffd3_8413,  // 30 addi x8, x7, -3
        32'h0080_2a23,  // 34 sw   x8, 20(x0)
        32'h0800_2483,  // 38 lw   x9, 128(x0)
        32'h0014_8533,  // 3c add  x10, x9, x1, load-use
        32'h00a0_2c23,  // 40 sw   x10, 24(x0)
        32'h0010_8463,  // 44 beq  x1, x1, +8 taken
        32'h0210_2e23,  // 48 sw   x1, 60(x0) sentinel
        32'h0020_8463,  // 4c beq  x1, x2, +8 not taken
        32'h0020_2e23,  // 50 sw   x2, 28(x0)
        32'h0080_05ef,  // 54 jal  x11, +8
        32'h0210_2e23,  // 58 sw   x1, 60(x0) sentinel
        32'h02b0_2023,  // 5c sw   x11, 32(x0)
        32'h0070_0013,  // 60 addi x0, x0, 7
        32'h0200_2223   // 64 sw   x0, 36(x0)
    };

    logic      clk;
    logic      rst;
    imemAddr_t imemAddr;
    logic      imemRe;
    word_t     imemData;
    word_t     dmemAddr;
    logic      dmemWrite;
    word_t     dmemWriteData;
    word_t     dmemReadData;

    word_t dmem [64];
    int    storeCount;
    int    errCount;    // bumped by the bound checker
    int    miscErrors;

    rvCore dut (
        .clk(clk), .rst(rst),
        .imemAddr(imemAddr), .imemRe(imemRe), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemWrite(dmemWrite),
        .dmemWriteData(dmemWriteData), .dmemReadData(dmemReadData)
    );

    bind rvCore rvCore_assert checks (
        .clk(clk), .rst(rst), .imemAddr(imemAddr), .imemRe(imemRe),
        .dmemAddr(dmemAddr), .dmemWrite(dmemWrite), .dmemWriteData(dmemWriteData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    //////////////////////////////////////////////////
    // memory models
    //////////////////////////////////////////////////
    assign imemData     = (imemAddr < progLen) ? progImage[imemAddr] : nopInstr; // nops past end
    assign dmemReadData = dmem[dmemAddr[7:2]];

    always @(posedge clk) begin
        if (dmemWrite) begin
            dmem[dmemAddr[7:2]] <= dmemWriteData;
            storeCount          <= storeCount + 1;
        end
    end

    // word holds its own byte address, so word 32 reads 0xd0000080
    task automatic fillDataMemory();
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'hd000_0000 | (i << 2);
        end
    endtask

    task automatic printSummary();
        $display("summary: %0d assertion errors, %0d other errors, %0d of %0d stores",
                 errCount, miscErrors, storeCount, numStores);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        rst        = 1'b1;
        storeCount = 0;
        errCount   = 0;
        miscErrors = 0;
        fillDataMemory();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (storeCount < numStores) begin
            @(negedge clk); // watchdog covers a stuck core
        end
        repeat (10) @(negedge clk); // trailing nops, catches late stray stores

        if (storeCount != numStores) begin
            $display("ERROR: expected %0d stores but saw %0d", numStores, storeCount);
            miscErrors++;
        end
        printSummary();
        if (errCount == 0 && miscErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("ERROR: watchdog timeout after %0d cycles with %0d of %0d stores seen",
                 watchdogCycles, storeCount, numStores);
        miscErrors++;
        printSummary();
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
hdl/rvCore_pkg.sv
hdl/controlDecoder.sv
hdl/regFile.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/hazardUnit.sv
hdl/memWbStage.sv
hdl/rvCore.sv
sim/rvCore_assert.sv
sim/rvCore_tb.sv
